//--- bench/busmaster_tb.sv
`timescale 1ns/1ps
`include "bus_params.svh"

module busmaster_tb;

	// Request count over all phases, sets the run limit
	localparam int N_REQ = 223;
	localparam int CYCLE_LIMIT = 40 * N_REQ + 200;
	// Slave regions as the bench sees them
	localparam int RGN_EXT = 0;
	localparam int RGN_MEM = 1;
	localparam int RGN_IO = 2;
	localparam int RGN_NONE = 3;

	// Expected response, kind is {err, ack}
	typedef struct packed
	{
		int due;
		logic [1:0] kind;
		logic chk;
		bus_pkg::data_t data;
	} rsp_exp_t;

	// External RAM answer waiting in the responder
	typedef struct packed
	{
		int due;
		bus_pkg::data_t data;
	} ram_pend_t;

	logic i_clk;
	logic i_arst_n;
	bus_pkg::bus_req_t i_req;
	logic o_ack;
	bus_pkg::data_t o_data;
	logic o_err;
	logic o_stall;
	logic [3:0] i_sw;
	logic [3:0] o_led;
	logic o_ram_cyc;
	logic o_ram_stb;
	logic o_ram_we;
	bus_pkg::ext_addr_t o_ram_addr;
	bus_pkg::data_t o_ram_wdata;
	bus_pkg::bsel_t o_ram_sel;
	logic i_ram_ack;
	logic i_ram_stall;
	bus_pkg::data_t i_ram_rdata;
	logic i_ram_err;

	int cycle;
	int wd_cycles;
	int errors;
	int checks;
	int last_ram_due;
	logic accepted;
	logic stall_en;
	logic spur;
	rsp_exp_t exp_q[$];
	ram_pend_t pend_q[$];
	// Reference model state
	bus_pkg::data_t mem_model [0:`MEM_WORDS-1];
	bus_pkg::data_t ram_model [0:(1 << `EXT_AW)-1];
	bus_pkg::data_t led_model;
	bus_pkg::data_t scratch_model;
	bus_pkg::addr_t err_model;
	// Responder storage, written from the DUT's RAM port
	bus_pkg::data_t ram_store [0:(1 << `EXT_AW)-1];
	// Block RAM words that hold known data
	bus_pkg::mem_idx_t mem_set [0:15];

	busmaster_top UUT
	(
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_req(i_req),
		.o_ack(o_ack),
		.o_data(o_data),
		.o_err(o_err),
		.o_stall(o_stall),
		.i_sw(i_sw),
		.o_led(o_led),
		.o_ram_cyc(o_ram_cyc),
		.o_ram_stb(o_ram_stb),
		.o_ram_we(o_ram_we),
		.o_ram_addr(o_ram_addr),
		.o_ram_wdata(o_ram_wdata),
		.o_ram_sel(o_ram_sel),
		.i_ram_ack(i_ram_ack),
		.i_ram_stall(i_ram_stall),
		.i_ram_rdata(i_ram_rdata),
		.i_ram_err(i_ram_err)
	);

	always #5 i_clk = ~i_clk;

	// Run limit
	always @(posedge i_clk)
	begin
		wd_cycles++;
		if (wd_cycles > CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Model helpers
	//////////////////////////////////////////////////

	function automatic int region_of(input bus_pkg::addr_t addr);
		if (addr[15])
			return RGN_EXT;
		if (addr[14] && addr[13:10] == 4'h0)
			return RGN_MEM;
		if (!addr[14] && addr[13:2] == 12'h0)
			return RGN_IO;
		return RGN_NONE;
	endfunction

	function automatic bus_pkg::data_t merge_bytes(input bus_pkg::data_t old_word,
		input bus_pkg::data_t new_word, input bus_pkg::bsel_t bsel);
		bus_pkg::data_t w;
		w = old_word;
		for (int b = 0; b < `BUS_SW; b++)
		begin
			if (bsel[b])
				w[8*b +: 8] = new_word[8*b +: 8];
		end
		return w;
	endfunction

	// Odd multiplier, so every word address gets its own pattern
	function automatic bus_pkg::data_t ram_fill(input int addr);
		return (addr * 32'h9e3779b1) ^ 32'h5a5a0f0f;
	endfunction

	function automatic bus_pkg::addr_t pick_mem_addr();
		return {2'b01, 4'h0, mem_set[4'($urandom())]};
	endfunction

	task automatic report_mismatch(input string name, input bus_pkg::data_t got,
		input bus_pkg::data_t want);
		$display("** Error: %s = %h, expected %h at cycle %0d", name, got, want, cycle);
		errors++;
	endtask

	//////////////////////////////////////////////////
	// One falling edge: check, accept, respond
	//////////////////////////////////////////////////

	task automatic next_cycle();
		rsp_exp_t e;
		ram_pend_t p;
		bus_pkg::mem_idx_t m_idx;
		bus_pkg::ext_addr_t x_idx;
		int rgn;
		logic pulse;
		logic stall_exp;
		@(negedge i_clk);
		cycle++;
		pulse = 1'b0;
		accepted = 1'b0;
		// Response due now, otherwise the return path stays quiet
		if (exp_q.size() > 0 && exp_q[0].due == cycle)
		begin
			e = exp_q.pop_front();
			checks++;
			assert ({o_err, o_ack} == e.kind)
			else
				report_mismatch("{o_err,o_ack}", 32'({o_err, o_ack}), 32'(e.kind));
			if (e.chk)
			begin
				checks++;
				assert (o_data == e.data)
				else
					report_mismatch("o_data", o_data, e.data);
			end
		end
		else
		begin
			checks++;
			assert (!o_ack && !o_err)
			else
				report_mismatch("{o_err,o_ack}", 32'({o_err, o_ack}), 32'h0);
		end
		// Only a strobed external request sees the RAM's back-pressure
		stall_exp = i_req.cyc && i_req.stb && (region_of(i_req.addr) == RGN_EXT)
			&& i_ram_stall;
		checks++;
		assert (o_stall == stall_exp)
		else
			report_mismatch("o_stall", 32'(o_stall), 32'(stall_exp));
		// Request seen at the last rising edge
		if (i_req.cyc && i_req.stb && !o_stall)
		begin
			accepted = 1'b1;
			rgn = region_of(i_req.addr);
			e.due = cycle + 1;
			e.kind = 2'b01;
			e.chk = !i_req.we;
			e.data = '0;
			case (rgn)
				RGN_EXT:
				begin
					checks += 2;
					assert ({o_ram_cyc, o_ram_stb, o_ram_we, o_ram_addr, o_ram_sel}
						== {2'b11, i_req.we, i_req.addr[`EXT_AW-1:0], i_req.bsel})
					else
						report_mismatch("{o_ram_cyc,o_ram_stb,o_ram_we,o_ram_addr,o_ram_sel}",
							32'({o_ram_cyc, o_ram_stb, o_ram_we, o_ram_addr, o_ram_sel}),
							32'({2'b11, i_req.we, i_req.addr[`EXT_AW-1:0], i_req.bsel}));
					assert (o_ram_wdata == i_req.data)
					else
						report_mismatch("o_ram_wdata", o_ram_wdata, i_req.data);
					x_idx = i_req.addr[`EXT_AW-1:0];
					e.data = ram_model[x_idx];
					if (i_req.we)
						ram_model[x_idx] = merge_bytes(ram_model[x_idx], i_req.data, i_req.bsel);
					// Responder, 1 to 3 cycles, never out of order
					if (o_ram_we)
						ram_store[o_ram_addr] = merge_bytes(ram_store[o_ram_addr],
							o_ram_wdata, o_ram_sel);
					p.data = ram_store[o_ram_addr];
					p.due = cycle + int'($urandom() % 3);
					if (p.due <= last_ram_due)
						p.due = last_ram_due + 1;
					last_ram_due = p.due;
					pend_q.push_back(p);
					e.due = p.due + 1;
				end
				RGN_MEM:
				begin
					m_idx = i_req.addr[`MEM_LG-1:0];
					e.data = mem_model[m_idx];
					if (i_req.we)
						mem_model[m_idx] = merge_bytes(mem_model[m_idx], i_req.data, i_req.bsel);
					// Stray RAM ack on top of the block RAM ack
					if (spur)
					begin
						pulse = 1'b1;
						e.kind = 2'b11;
						e.chk = 1'b0;
					end
				end
				RGN_IO:
				begin
					case (i_req.addr[1:0])
						2'd0: e.data = {28'h0, i_sw};
						2'd1: e.data = led_model;
						2'd2: e.data = {16'h0, err_model};
						default: e.data = scratch_model;
					endcase
					if (i_req.we && i_req.addr[1:0] == 2'd1)
						led_model = i_req.data;
					if (i_req.we && i_req.addr[1:0] == 2'd3)
						scratch_model = i_req.data;
				end
				default:
				begin
					// Decode miss
					e.kind = 2'b10;
					e.chk = 1'b0;
					err_model = i_req.addr;
				end
			endcase
			if (rgn != RGN_EXT)
			begin
				checks++;
				assert (!o_ram_stb)
				else
					report_mismatch("o_ram_stb", 32'(o_ram_stb), 32'h0);
			end
			exp_q.push_back(e);
		end
		checks++;
		assert (o_led == led_model[3:0])
		else
			report_mismatch("o_led", 32'(o_led), 32'(led_model[3:0]));
		// External RAM side for the coming cycle
		i_ram_ack = pulse;
		i_ram_rdata = $urandom();
		if (pend_q.size() > 0 && pend_q[0].due == cycle)
		begin
			p = pend_q.pop_front();
			i_ram_ack = 1'b1;
			i_ram_rdata = p.data;
		end
		i_ram_stall = stall_en && ($urandom() % 3 == 0);
	endtask

	// Hold the request until it is taken
	task automatic send_request(input logic we, input bus_pkg::addr_t addr,
		input bus_pkg::data_t data, input bus_pkg::bsel_t bsel);
		i_req.stb = 1'b1;
		i_req.we = we;
		i_req.addr = addr;
		i_req.data = data;
		i_req.bsel = bsel;
		accepted = 1'b0;
		while (!accepted)
			next_cycle();
		i_req.stb = 1'b0;
	endtask

	task automatic wait_idle();
		i_req.stb = 1'b0;
		while (exp_q.size() > 0 || pend_q.size() > 0)
			next_cycle();
		next_cycle();
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial
	begin
		bus_pkg::addr_t bad;
		void'($urandom(31));
		i_clk = 1'b0;
		i_arst_n = 1'b0;
		i_req = '0;
		i_sw = 4'h0;
		i_ram_ack = 1'b0;
		i_ram_stall = 1'b0;
		i_ram_rdata = '0;
		i_ram_err = 1'b0;
		cycle = 0;
		wd_cycles = 0;
		errors = 0;
		checks = 0;
		last_ram_due = -1;
		accepted = 1'b0;
		stall_en = 1'b0;
		spur = 1'b0;
		led_model = '0;
		scratch_model = '0;
		err_model = '0;
		for (int a = 0; a < (1 << `EXT_AW); a++)
		begin
			ram_model[a] = ram_fill(a);
			ram_store[a] = ram_fill(a);
		end
		repeat (10) @(negedge i_clk);
		i_arst_n = 1'b1;
		i_req.cyc = 1'b1;
		i_sw = 4'($urandom());

		// Reset values of LED and error address, then the switches
		send_request(1'b0, 16'h0001, '0, '0);
		send_request(1'b0, 16'h0002, '0, '0);
		send_request(1'b0, 16'h0000, '0, '0);
		wait_idle();

		// Block RAM: full words, byte merges, read-back
		for (int k = 0; k < 16; k++)
			mem_set[k] = bus_pkg::mem_idx_t'($urandom());
		for (int k = 0; k < 16; k++)
			send_request(1'b1, {2'b01, 4'h0, mem_set[k]}, $urandom(), 4'hf);
		for (int k = 0; k < 32; k++)
			send_request(1'b1, pick_mem_addr(), $urandom(), 4'($urandom()));
		for (int k = 0; k < 16; k++)
			send_request(1'b0, {2'b01, 4'h0, mem_set[k]}, '0, '0);
		wait_idle();

		// Register page
		for (int k = 0; k < 8; k++)
		begin
			i_sw = 4'($urandom());
			send_request(1'b1, 16'h0001, $urandom(), 4'hf);
			send_request(1'b1, 16'h0003, $urandom(), 4'($urandom()));
			send_request(1'b0, 16'h0003, '0, '0);
			send_request(1'b0, 16'h0000, '0, '0);
			send_request(1'b0, 16'h0001, '0, '0);
		end
		wait_idle();

		// External RAM with random back-pressure
		stall_en = 1'b1;
		for (int k = 0; k < 64; k++)
			send_request(1'($urandom()), 16'h8000 | 16'($urandom() & 32'h70ff),
				$urandom(), 4'($urandom()));
		wait_idle();
		stall_en = 1'b0;
		i_ram_stall = 1'b0;

		// Decode misses, alternating block RAM gap and register page gap
		for (int k = 0; k < 8; k++)
		begin
			if (k % 2 == 0)
				bad = 16'(32'h4000 | ((1 + $urandom() % 15) << 10) | ($urandom() % 1024));
			else
				bad = 16'(((1 + $urandom() % 4095) << 2) | ($urandom() % 4));
			send_request(1'($urandom()), bad, $urandom(), 4'hf);
			// Captured address reaches the register page one edge later
			next_cycle();
			send_request(1'b0, 16'h0002, '0, '0);
		end
		wait_idle();

		// Two acks in one cycle
		spur = 1'b1;
		for (int k = 0; k < 4; k++)
			send_request(1'b0, {2'b01, 4'h0, mem_set[k]}, '0, '0);
		spur = 1'b0;
		wait_idle();

		// Local reads with no idle cycles
		for (int k = 0; k < 32; k++)
		begin
			if ($urandom() % 2 == 0)
				send_request(1'b0, pick_mem_addr(), '0, '0);
			else
				send_request(1'b0, {14'h0, 2'($urandom())}, '0, '0);
		end
		wait_idle();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- build.f
+incdir+source
source/bus_pkg.sv
source/bus_decode.sv
source/block_ram.sv
source/io_regs.sv
source/bus_resp.sv
source/busmaster_top.sv
bench/busmaster_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module busmaster_tb

# A stopped simulation still leaves its output for the search below
out=$(./obj_dir/Vbusmaster_tb) || true
echo "$out"

grep -qx "TEST PASSED" <<< "$out"

//--- source/block_ram.sv
`timescale 1ns/1ps
`include "bus_params.svh"

module block_ram
(
	input logic i_clk,
	input logic i_arst_n,
	input bus_pkg::bus_req_t i_req,
	input logic i_stb,
	output bus_pkg::slave_rsp_t o_rsp
);

	// Word storage
	bus_pkg::data_t mem [0:`MEM_WORDS-1];
	// Low address bits
	bus_pkg::mem_idx_t idx;
	// Registered answer
	bus_pkg::data_t rdata_q;
	logic ack_q;

	assign idx = i_req.addr[`MEM_LG-1:0];

	// Byte lane writes
	always_ff @(posedge i_clk)
	begin
		if (i_stb && i_req.we)
		begin
			for (int b = 0; b < `BUS_SW; b++)
			begin
				if (i_req.bsel[b])
					mem[idx][8*b +: 8] <= i_req.data[8*b +: 8];
			end
		end
	end

	// Old word comes back on writes too
	always_ff @(posedge i_clk)
	begin
		if (i_stb)
			rdata_q <= mem[idx];
	end

	// One ack per strobe, never stalls
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			ack_q <= 1'b0;
		else
			ack_q <= i_stb;
	end

	assign o_rsp = '{ack: ack_q, data: rdata_q};

	// Strobes only arrive inside a live bus request
	a_ack_after_stb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_rsp.ack |-> $past(i_stb && i_req.cyc && i_req.stb));

endmodule

//--- source/bus_decode.sv
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_decode
(
	input logic i_clk,
	input logic i_arst_n,
	input bus_pkg::bus_req_t i_req,
	input logic i_ram_stall,
	output bus_pkg::slave_stb_t o_stb,
	output logic o_stall,
	output logic o_sel_err,
	output bus_pkg::addr_t o_sel_err_addr
);

	// Live request strobe
	logic req_stb;
	// Top two address bits
	logic [1:0] region;
	// Region hits with the unused bits checked
	logic hit_ext;
	logic hit_mem;
	logic hit_io;
	// Strobed address that lands nowhere
	logic miss;

	//////////////////////////////////////////////////
	// Region decode
	//////////////////////////////////////////////////

	assign req_stb = i_req.cyc && i_req.stb;
	assign region = i_req.addr[`BUS_AW-1 -: 2];

	// Top bit alone picks the external RAM
	assign hit_ext = (region[1] == `RGN_EXT);
	// Block RAM, gap bits above the index must be clear
	assign hit_mem = (region == `RGN_MEM) && ~|i_req.addr[`BUS_AW-3:`MEM_LG];
	// Register page, same idea with a tiny index
	assign hit_io = (region == `RGN_IO) && ~|i_req.addr[`BUS_AW-3:`IO_LG];

	assign miss = req_stb && !(hit_ext || hit_mem || hit_io);

	// Per-slave strobes
	assign o_stb = '{
		ext: req_stb && hit_ext,
		mem: req_stb && hit_mem,
		io: req_stb && hit_io
	};

	// Only the external RAM pushes back
	assign o_stall = o_stb.ext && i_ram_stall;

	//////////////////////////////////////////////////
	// Select error capture
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_sel_err <= 1'b0;
		else
			o_sel_err <= miss;
	end

	// Offending address, held until the next miss
	always_ff @(posedge i_clk)
	begin
		if (miss)
			o_sel_err_addr <= i_req.addr;
	end

	// Disjoint regions
	a_one_stb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$onehot0(o_stb));

endmodule

//--- source/bus_params.svh
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

// Word address
`define BUS_AW 16
// Data word
`define BUS_DW 32
// Byte selects, one per data byte
`define BUS_SW 4

//////////////////////////////////////////////////
// Slave sizes
//////////////////////////////////////////////////

// Block RAM depth as log2 of words
`define MEM_LG 10
`define MEM_WORDS (1 << `MEM_LG)
// Register page depth as log2 of registers
`define IO_LG 2
// External RAM word address
`define EXT_AW 15

//////////////////////////////////////////////////
// Region codes in the top address bits
//////////////////////////////////////////////////

// External RAM needs only the top bit
`define RGN_EXT 1'b1
`define RGN_MEM 2'b01
`define RGN_IO 2'b00

`endif

//--- source/bus_pkg.sv
`include "bus_params.svh"

package bus_pkg;

	// Word address on the bus
	typedef logic [`BUS_AW-1:0] addr_t;
	// One bus word
	typedef logic [`BUS_DW-1:0] data_t;
	// Byte lane selects
	typedef logic [`BUS_SW-1:0] bsel_t;
	// Word address toward the external RAM
	typedef logic [`EXT_AW-1:0] ext_addr_t;
	// Block RAM word index
	typedef logic [`MEM_LG-1:0] mem_idx_t;
	// Register page index
	typedef logic [`IO_LG-1:0] io_idx_t;

	// Request from the bus commander
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		addr_t addr;
		data_t data;
		bsel_t bsel;
	} bus_req_t;

	// One strobe per slave, also reused for acks
	typedef struct packed
	{
		logic ext;
		logic mem;
		logic io;
	} slave_stb_t;

	// Local slave answer
	typedef struct packed
	{
		logic ack;
		data_t data;
	} slave_rsp_t;

endpackage

//--- source/bus_resp.sv
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_resp
(
	input logic i_clk,
	input logic i_arst_n,
	input logic i_cyc,
	input bus_pkg::slave_rsp_t i_mem_rsp,
	input bus_pkg::slave_rsp_t i_io_rsp,
	input logic i_ram_ack,
	input bus_pkg::data_t i_ram_rdata,
	input logic i_ram_err,
	input logic i_sel_err,
	input bus_pkg::addr_t i_sel_err_addr,
	output logic o_ack,
	output bus_pkg::data_t o_data,
	output logic o_err,
	output bus_pkg::addr_t o_err_addr
);

	// All slave acks side by side
	bus_pkg::slave_stb_t acks;
	// Two or more in one cycle
	logic multi_ack;
	logic ack_q;
	logic err_q;
	bus_pkg::data_t data_q;
	bus_pkg::addr_t err_addr_q;

	assign acks = '{
		ext: i_ram_ack,
		mem: i_mem_rsp.ack,
		io: i_io_rsp.ack
	};

	// Pairwise overlap
	assign multi_ack = (acks.ext && acks.mem)
		|| (acks.ext && acks.io)
		|| (acks.mem && acks.io);

	//////////////////////////////////////////////////
	// Return path
	//////////////////////////////////////////////////

	// Ack only inside a bus cycle
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			ack_q <= 1'b0;
		else
			ack_q <= i_cyc && (|acks);
	end

	// External first, then block RAM, then registers
	always_ff @(posedge i_clk)
	begin
		if (acks.ext)
			data_q <= i_ram_rdata;
		else if (acks.mem)
			data_q <= i_mem_rsp.data;
		else
			data_q <= i_io_rsp.data;
	end

	assign o_ack = ack_q;
	assign o_data = data_q;

	//////////////////////////////////////////////////
	// Bus errors
	//////////////////////////////////////////////////

	// Collisions and decode misses
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			err_q <= 1'b0;
		else
			err_q <= i_cyc && (multi_ack || i_sel_err);
	end

	// External RAM error goes straight through
	assign o_err = i_cyc && (err_q || i_ram_err);

	// Last decode miss address for the register page
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			err_addr_q <= '0;
		else if (i_sel_err)
			err_addr_q <= i_sel_err_addr;
	end

	assign o_err_addr = err_addr_q;

	// No error outside a bus cycle
	a_err_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_err |-> i_cyc);

endmodule

//--- source/busmaster_top.sv
`timescale 1ns/1ps

module busmaster_top
(
	input logic i_clk,
	input logic i_arst_n,
	// Bus commander
	input bus_pkg::bus_req_t i_req,
	output logic o_ack,
	output bus_pkg::data_t o_data,
	output logic o_err,
	output logic o_stall,
	// Board I/O
	input logic [3:0] i_sw,
	output logic [3:0] o_led,
	// External RAM
	output logic o_ram_cyc,
	output logic o_ram_stb,
	output logic o_ram_we,
	output bus_pkg::ext_addr_t o_ram_addr,
	output bus_pkg::data_t o_ram_wdata,
	output bus_pkg::bsel_t o_ram_sel,
	input logic i_ram_ack,
	input logic i_ram_stall,
	input bus_pkg::data_t i_ram_rdata,
	input logic i_ram_err
);

	// Decoder outputs
	bus_pkg::slave_stb_t stb;
	logic sel_err;
	bus_pkg::addr_t sel_err_addr;
	// Local slave answers
	bus_pkg::slave_rsp_t mem_rsp;
	bus_pkg::slave_rsp_t io_rsp;
	// Held error address for the register page
	bus_pkg::addr_t err_addr;

	bus_decode u_decode
	(
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_req(i_req),
		.i_ram_stall(i_ram_stall),
		.o_stb(stb),
		.o_stall(o_stall),
		.o_sel_err(sel_err),
		.o_sel_err_addr(sel_err_addr)
	);

	// External RAM rides the commander's wires
	assign o_ram_cyc = i_req.cyc;
	assign o_ram_stb = stb.ext;
	assign o_ram_we = i_req.we;
	assign o_ram_addr = i_req.addr[$bits(bus_pkg::ext_addr_t)-1:0];
	assign o_ram_wdata = i_req.data;
	assign o_ram_sel = i_req.bsel;

	block_ram u_mem
	(
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_req(i_req),
		.i_stb(stb.mem),
		.o_rsp(mem_rsp)
	);

	io_regs u_io
	(
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_req(i_req),
		.i_stb(stb.io),
		.i_sw(i_sw),
		.i_err_addr(err_addr),
		.o_led(o_led),
		.o_rsp(io_rsp)
	);

	bus_resp u_resp
	(
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_cyc(i_req.cyc),
		.i_mem_rsp(mem_rsp),
		.i_io_rsp(io_rsp),
		.i_ram_ack(i_ram_ack),
		.i_ram_rdata(i_ram_rdata),
		.i_ram_err(i_ram_err),
		.i_sel_err(sel_err),
		.i_sel_err_addr(sel_err_addr),
		.o_ack(o_ack),
		.o_data(o_data),
		.o_err(o_err),
		.o_err_addr(err_addr)
	);

endmodule

//--- source/io_regs.sv
`timescale 1ns/1ps
`include "bus_params.svh"

module io_regs
(
	input logic i_clk,
	input logic i_arst_n,
	input bus_pkg::bus_req_t i_req,
	input logic i_stb,
	input logic [3:0] i_sw,
	input bus_pkg::addr_t i_err_addr,
	output logic [3:0] o_led,
	output bus_pkg::slave_rsp_t o_rsp
);

	// Register map
	localparam bus_pkg::io_idx_t IDX_SW = 2'd0;
	localparam bus_pkg::io_idx_t IDX_LED = 2'd1;
	localparam bus_pkg::io_idx_t IDX_ERR = 2'd2;
	localparam bus_pkg::io_idx_t IDX_SCR = 2'd3;

	bus_pkg::io_idx_t idx;
	// Writable registers
	bus_pkg::data_t led_q;
	bus_pkg::data_t scratch_q;
	// Read mux and registered answer
	bus_pkg::data_t rd_mux;
	bus_pkg::data_t rdata_q;
	logic ack_q;
	logic wr;

	assign idx = i_req.addr[`IO_LG-1:0];
	assign wr = i_stb && i_req.we;

	//////////////////////////////////////////////////
	// Writable registers
	//////////////////////////////////////////////////

	// Full word writes, byte selects ignored
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			led_q <= '0;
			scratch_q <= '0;
		end
		else if (wr)
		begin
			if (idx == IDX_LED)
				led_q <= i_req.data;
			if (idx == IDX_SCR)
				scratch_q <= i_req.data;
		end
	end

	// Only the low nibble reaches the board
	assign o_led = led_q[3:0];

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////

	always_comb
	begin
		case (idx)
			IDX_SW: rd_mux = bus_pkg::data_t'(i_sw);
			IDX_LED: rd_mux = led_q;
			IDX_ERR: rd_mux = bus_pkg::data_t'(i_err_addr);
			default: rd_mux = scratch_q;
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (i_stb)
			rdata_q <= rd_mux;
	end

	// Answer one edge after the strobe
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			ack_q <= 1'b0;
		else
			ack_q <= i_stb;
	end

	assign o_rsp = '{ack: ack_q, data: rdata_q};

endmodule
